/* verilog/edge_bank_pkg.sv */
`default_nettype none

package edge_bank_pkg;

    // bank geometry
    localparam int num_pe     = 4;
    localparam int bank_idx_w = $clog2(num_pe);
    localparam int buf_depth  = 8;
    // holds a count up to buf_depth, not just an address
    localparam int ptr_w      = $clog2(buf_depth + 1);
    localparam int fv_w       = 16;

    // wishbone register map
    localparam logic [1:0] reg_enable_adr = 2'd0;
    localparam logic [1:0] reg_count_adr  = 2'd1;
    localparam logic [1:0] reg_busy_adr   = 2'd2;

    // two feature values per word
    typedef logic [2*fv_w-1:0] fv_pair_t;
    typedef logic [num_pe-1:0] bank_mask_t;
    typedef logic [15:0]       burst_cnt_t;
    typedef logic [1:0]        wb_adr_t;
    typedef logic [31:0]       wb_data_t;

    typedef enum logic [1:0] {FILL, READY, DRAIN} bank_state_t;
    typedef enum logic {IDLE, BLOCKED} arb_state_t;

endpackage

`default_nettype wire

/* verilog/bank_stream_if.sv */
`timescale 1ns/100ps
`default_nettype none

// one bank's burst toward the arbitration block
interface bank_stream_if import edge_bank_pkg::*; ();
    logic     req;
    logic     valid;
    logic     sos;
    logic     eos;
    fv_pair_t data;
    // one-cycle grant pulse
    logic     grant;
    // rs_available passed down
    logic     ready;

    modport bank (output req, valid, sos, eos, data, input grant, ready);
    modport arbiter (input req, valid, sos, eos, data, output grant, ready);
endinterface

`default_nettype wire

/* verilog/edge_buffer_one.sv */
`timescale 1ns/100ps
`default_nettype none

module edge_buffer_one import edge_bank_pkg::*; (
    input  logic        clk,
    input  logic        reset,
    input  logic        pe_valid,
    input  logic        pe_sos,
    input  logic        pe_eos,
    input  fv_pair_t    pe_data,
    output logic        bank_busy,
    bank_stream_if.bank stream
);
    // burst storage
    fv_pair_t         mem [buf_depth];
    logic [ptr_w-1:0] wr_ptr;
    logic [ptr_w-1:0] wr_addr;
    logic [ptr_w-1:0] rd_ptr;
    logic [ptr_w-1:0] len;
    bank_state_t      state;
    logic             accept;
    logic             last_word;
    logic             word_out;

    // words only taken while filling
    assign accept    = pe_valid && (state == FILL);
    // sos restarts at address zero
    assign wr_addr   = pe_sos ? '0 : wr_ptr;
    assign last_word = (rd_ptr == len - ptr_w'(1));
    assign word_out  = stream.valid && stream.ready;

    assign bank_busy    = (state != FILL);
    assign stream.req   = (state == READY);
    assign stream.valid = (state == DRAIN);
    assign stream.sos   = (state == DRAIN) && (rd_ptr == '0);
    assign stream.eos   = (state == DRAIN) && last_word;
    assign stream.data  = mem[rd_ptr[ptr_w-2:0]];

    always_ff @(posedge clk) begin
        if (accept) begin
            mem[wr_addr[ptr_w-2:0]] <= pe_data;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            state  <= FILL;
            wr_ptr <= '0;
            rd_ptr <= '0;
            len    <= '0;
        end else begin
            case (state)
                FILL: begin
                    if (accept) begin
                        wr_ptr <= wr_addr + ptr_w'(1);
                        // eos word closes the burst
                        if (pe_eos) begin
                            len   <= wr_addr + ptr_w'(1);
                            state <= READY;
                        end
                    end
                end
                READY: begin
                    if (stream.grant) begin
                        rd_ptr <= '0;
                        state  <= DRAIN;
                    end
                end
                DRAIN: begin
                    // advance only when the rs takes the word
                    if (word_out) begin
                        rd_ptr <= rd_ptr + ptr_w'(1);
                        if (last_word) begin
                            wr_ptr <= '0;
                            state  <= FILL;
                        end
                    end
                end
                default: state <= FILL;
            endcase
        end
    end

endmodule

`default_nettype wire

/* verilog/rr_arbiter.sv */
`timescale 1ns/100ps
`default_nettype none

module rr_arbiter #(
    parameter int num_reqs = 4
) (
    input  logic                clk,
    input  logic                reset,
    input  logic [num_reqs-1:0] reqs,
    output logic [num_reqs-1:0] grants
);
    // set bits mark positions after the last grant
    logic [num_reqs-1:0] ptr_mask;
    logic [num_reqs-1:0] masked_reqs;
    logic [num_reqs-1:0] next_mask;
    logic [num_reqs-1:0] shifted;

    assign masked_reqs = reqs & ptr_mask;

    // lowest set bit wins, masked set first
    always_comb begin
        if (|masked_reqs) begin
            grants = masked_reqs & (~masked_reqs + {{(num_reqs-1){1'b0}}, 1'b1});
        end else begin
            grants = reqs & (~reqs + {{(num_reqs-1){1'b0}}, 1'b1});
        end
    end

    // bits strictly above the granted one
    assign shifted   = {grants[num_reqs-2:0], 1'b0};
    assign next_mask = ~(shifted - {{(num_reqs-1){1'b0}}, 1'b1});

    always_ff @(posedge clk) begin
        if (reset) begin
            // bank 0 first after reset
            ptr_mask <= '1;
        end else if (|grants) begin
            ptr_mask <= next_mask;
        end
    end

endmodule

`default_nettype wire

/* verilog/edge_buffer.sv */
`timescale 1ns/100ps
`default_nettype none

module edge_buffer import edge_bank_pkg::*; (
    input  logic       clk,
    input  logic       reset,
    input  bank_mask_t pe_valid,
    input  bank_mask_t pe_sos,
    input  bank_mask_t pe_eos,
    input  fv_pair_t   pe_data [num_pe],
    input  bank_mask_t bank_enable,
    input  logic       rs_available,
    output bank_mask_t bank_busy,
    output logic       rs_valid,
    output logic       rs_sos,
    output logic       rs_eos,
    output fv_pair_t   rs_data
);
    bank_stream_if streams [num_pe] ();

    bank_mask_t            bank_req;
    bank_mask_t            bank_valid;
    bank_mask_t            bank_sos;
    bank_mask_t            bank_eos;
    fv_pair_t              bank_data [num_pe];
    bank_mask_t            masked_req;
    bank_mask_t            grant_pulse;
    bank_mask_t            grant_last;
    logic [bank_idx_w-1:0] sel_idx;
    logic                  sel_any;
    arb_state_t            state;

    for (genvar i = 0; i < num_pe; i++) begin : g_bank
        edge_buffer_one u_bank (
            .clk      (clk),
            .reset    (reset),
            .pe_valid (pe_valid[i]),
            .pe_sos   (pe_sos[i]),
            .pe_eos   (pe_eos[i]),
            .pe_data  (pe_data[i]),
            .bank_busy(bank_busy[i]),
            .stream   (streams[i])
        );
        // arbiter side of each stream
        assign streams[i].grant = grant_pulse[i];
        assign streams[i].ready = rs_available;
        assign bank_req[i]      = streams[i].req;
        assign bank_valid[i]    = streams[i].valid;
        assign bank_sos[i]      = streams[i].sos;
        assign bank_eos[i]      = streams[i].eos;
        assign bank_data[i]     = streams[i].data;
    end

    // no requests while a burst is in flight or the rs is stalled
    // the grant edge moves us to BLOCKED, so a second grant cannot follow
    assign masked_req = (state == BLOCKED || !rs_available) ? '0 : (bank_req & bank_enable);

    rr_arbiter #(.num_reqs(num_pe)) u_arb (
        .clk   (clk),
        .reset (reset),
        .reqs  (masked_req),
        .grants(grant_pulse)
    );

    always_ff @(posedge clk) begin
        if (reset) begin
            state      <= IDLE;
            grant_last <= '0;
        end else if (state == IDLE) begin
            if (|grant_pulse) begin
                state      <= BLOCKED;
                grant_last <= grant_pulse;
            end
        end else if (rs_eos) begin
            // last word of the burst left
            state      <= IDLE;
            grant_last <= '0;
        end
    end

    // one-hot remembered grant to index
    always_comb begin
        sel_idx = '0;
        for (int i = 0; i < num_pe; i++) begin
            if (grant_last[i]) begin
                sel_idx = bank_idx_w'(i);
            end
        end
    end

    assign sel_any  = |grant_last;
    assign rs_valid = sel_any && bank_valid[sel_idx] && rs_available;
    assign rs_sos   = rs_valid && bank_sos[sel_idx];
    assign rs_eos   = rs_valid && bank_eos[sel_idx];
    assign rs_data  = sel_any ? bank_data[sel_idx] : '0;

endmodule

`default_nettype wire

/* verilog/bank_config_regs.sv */
`timescale 1ns/100ps
`default_nettype none

module bank_config_regs import edge_bank_pkg::*; (
    input  logic       clk,
    input  logic       reset,
    input  logic       wb_cyc,
    input  logic       wb_stb,
    input  logic       wb_we,
    input  wb_adr_t    wb_adr,
    input  wb_data_t   wb_dat_w,
    output wb_data_t   wb_dat_r,
    output logic       wb_ack,
    input  bank_mask_t bank_busy,
    input  logic       burst_done,
    output bank_mask_t bank_enable
);
    burst_cnt_t burst_cnt;
    logic       wb_req;

    // new access, ack must have dropped first
    assign wb_req = wb_cyc && wb_stb && !wb_ack;

    // single-pulse ack
    always_ff @(posedge clk) begin
        if (reset) begin
            wb_ack <= 1'b0;
        end else begin
            wb_ack <= wb_req;
        end
    end

    // writes land on the ack edge
    always_ff @(posedge clk) begin
        if (reset) begin
            bank_enable <= '1;
        end else if (wb_req && wb_we && (wb_adr == reg_enable_adr)) begin
            bank_enable <= wb_dat_w[num_pe-1:0];
        end
    end

    // completed rs bursts
    always_ff @(posedge clk) begin
        if (reset) begin
            burst_cnt <= '0;
        end else if (burst_done) begin
            burst_cnt <= burst_cnt + 16'd1;
        end
    end

    // read data valid with the ack
    always_ff @(posedge clk) begin
        if (wb_req && !wb_we) begin
            case (wb_adr)
                reg_enable_adr: wb_dat_r <= wb_data_t'(bank_enable);
                reg_count_adr:  wb_dat_r <= wb_data_t'(burst_cnt);
                reg_busy_adr:   wb_dat_r <= wb_data_t'(bank_busy);
                // unmapped reads as zero
                default:        wb_dat_r <= '0;
            endcase
        end
    end

endmodule

`default_nettype wire

/* verilog/edge_bank_top.sv */
`timescale 1ns/100ps
`default_nettype none

module edge_bank_top import edge_bank_pkg::*; (
    input  logic       clk,
    input  logic       reset,
    // pe side, one bit per bank
    input  bank_mask_t pe_valid,
    input  bank_mask_t pe_sos,
    input  bank_mask_t pe_eos,
    input  fv_pair_t   pe_data [num_pe],
    output bank_mask_t bank_busy,
    // rs side
    input  logic       rs_available,
    output logic       rs_valid,
    output logic       rs_sos,
    output logic       rs_eos,
    output fv_pair_t   rs_data,
    // wishbone classic slave
    input  logic       wb_cyc,
    input  logic       wb_stb,
    input  logic       wb_we,
    input  wb_adr_t    wb_adr,
    input  wb_data_t   wb_dat_w,
    output wb_data_t   wb_dat_r,
    output logic       wb_ack
);
    bank_mask_t bank_enable;
    logic       burst_done;

    // one count per eos word delivered
    assign burst_done = rs_valid && rs_eos;

    edge_buffer u_edge_buffer (
        .clk         (clk),
        .reset       (reset),
        .pe_valid    (pe_valid),
        .pe_sos      (pe_sos),
        .pe_eos      (pe_eos),
        .pe_data     (pe_data),
        .bank_enable (bank_enable),
        .rs_available(rs_available),
        .bank_busy   (bank_busy),
        .rs_valid    (rs_valid),
        .rs_sos      (rs_sos),
        .rs_eos      (rs_eos),
        .rs_data     (rs_data)
    );

    bank_config_regs u_regs (
        .clk        (clk),
        .reset      (reset),
        .wb_cyc     (wb_cyc),
        .wb_stb     (wb_stb),
        .wb_we      (wb_we),
        .wb_adr     (wb_adr),
        .wb_dat_w   (wb_dat_w),
        .wb_dat_r   (wb_dat_r),
        .wb_ack     (wb_ack),
        .bank_busy  (bank_busy),
        .burst_done (burst_done),
        .bank_enable(bank_enable)
    );

endmodule

`default_nettype wire

/* testbench/edge_bank_properties.sv */
`timescale 1ns/100ps
`default_nettype none

module edge_bank_properties import edge_bank_pkg::*; (
    input logic       clk,
    input logic       reset,
    input bank_mask_t pe_valid,
    input bank_mask_t pe_sos,
    input bank_mask_t pe_eos,
    input bank_mask_t bank_busy,
    input logic       rs_available,
    input logic       rs_valid,
    input logic       rs_sos,
    input logic       rs_eos,
    input logic       wb_ack
);
    // high between an rs sos word and its eos word
    logic in_burst;

    always_ff @(posedge clk) begin
        if (reset) begin
            in_burst <= 1'b0;
        end else if (rs_valid && rs_eos) begin
            in_burst <= 1'b0;
        end else if (rs_valid && rs_sos) begin
            in_burst <= 1'b1;
        end
    end

    no_valid_when_stalled: assert property (@(posedge clk) disable iff (reset)
        rs_valid |-> rs_available)
        else $error("rs_valid while rs_available is low");

    no_nested_sos: assert property (@(posedge clk) disable iff (reset)
        (rs_valid && rs_sos) |-> !in_burst)
        else $error("rs_sos inside an open burst");

    single_cycle_ack: assert property (@(posedge clk) disable iff (reset)
        wb_ack |=> !wb_ack)
        else $error("wb_ack longer than one cycle");

    no_write_while_busy: assert property (@(posedge clk) disable iff (reset)
        (pe_valid & bank_busy) == '0)
        else $error("pe word offered to a busy bank");

    for (genvar i = 0; i < num_pe; i++) begin : g_len
        // words taken so far in the open pe burst
        logic [ptr_w-1:0] words;

        always_ff @(posedge clk) begin
            if (reset) begin
                words <= '0;
            end else if (pe_valid[i] && !bank_busy[i]) begin
                if (pe_eos[i]) begin
                    words <= '0;
                end else if (pe_sos[i]) begin
                    words <= ptr_w'(1);
                end else begin
                    words <= words + ptr_w'(1);
                end
            end
        end

        burst_fits: assert property (@(posedge clk) disable iff (reset)
            (pe_valid[i] && !bank_busy[i] && !pe_sos[i]) |-> (words < ptr_w'(buf_depth)))
            else $error("bank %0d burst longer than the bank depth", i);
    end

endmodule

bind edge_bank_top edge_bank_properties u_props (
    .clk         (clk),
    .reset       (reset),
    .pe_valid    (pe_valid),
    .pe_sos      (pe_sos),
    .pe_eos      (pe_eos),
    .bank_busy   (bank_busy),
    .rs_available(rs_available),
    .rs_valid    (rs_valid),
    .rs_sos      (rs_sos),
    .rs_eos      (rs_eos),
    .wb_ack      (wb_ack)
);

`default_nettype wire

/* testbench/tb_edge_bank.sv */
`timescale 1ns/100ps
`default_nettype none

module tb_edge_bank import edge_bank_pkg::*; ();

    // about 40 bursts of up to buf_depth words and up to 10x slower under stalls
    localparam int timeout_cycles = 40 * buf_depth * 10 + 800;

    logic       clk;
    logic       reset;
    bank_mask_t pe_valid;
    bank_mask_t pe_sos;
    bank_mask_t pe_eos;
    fv_pair_t   pe_data [num_pe];
    bank_mask_t bank_busy;
    logic       rs_available;
    logic       rs_valid;
    logic       rs_sos;
    logic       rs_eos;
    fv_pair_t   rs_data;
    logic       wb_cyc;
    logic       wb_stb;
    logic       wb_we;
    wb_adr_t    wb_adr;
    wb_data_t   wb_dat_w;
    wb_data_t   wb_dat_r;
    logic       wb_ack;

    // expected words per bank and a model of the arbitration
    fv_pair_t              exp_q [num_pe][$];
    bank_mask_t            ready_m;
    bank_mask_t            mask_m;
    logic                  blocked_m;
    logic [bank_idx_w-1:0] cur_bank;
    logic [bank_idx_w-1:0] rr_last;
    int                    word_idx;
    int                    rs_words;
    int                    last_len;
    int                    sos_cycle;
    int                    eos_cycle [num_pe];
    int                    eos_count;
    integer                seed = 32'hc864;
    int                    cycle = 0;
    int                    errors = 0;
    int                    checks = 0;
    logic                  throttle;
    string                 test_name;

    edge_bank_top DUT (.*);

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    task automatic check_value(input string what, input logic [31:0] expected,
                               input logic [31:0] actual);
        checks++;
        assert (actual === expected) else begin
            errors++;
            $display("mismatch %s %s: expected %h, actual %h", test_name, what, expected, actual);
        end
    endtask

    task automatic report_error(input string msg);
        errors++;
        $display("error in %s: %s", test_name, msg);
    endtask

    function automatic int pick_length();
        return 1 + int'($unsigned($random(seed)) % buf_depth);
    endfunction

    // one classic cycle with the ack awaited on rising edges
    task automatic wb_access(input logic we, input wb_adr_t adr, input wb_data_t wdata,
                             output wb_data_t rdata);
        int waits;
        waits = 0;
        @(negedge clk);
        wb_cyc   = 1'b1;
        wb_stb   = 1'b1;
        wb_we    = we;
        wb_adr   = adr;
        wb_dat_w = wdata;
        @(posedge clk);
        while (!wb_ack) begin
            waits++;
            @(posedge clk);
        end
        // ack one cycle after the strobe
        check_value("wb_ack delay", 32'd1, 32'(waits));
        rdata = wb_dat_r;
        @(negedge clk);
        wb_cyc = 1'b0;
        wb_stb = 1'b0;
        wb_we  = 1'b0;
    endtask

    task automatic send_burst(input logic [bank_idx_w-1:0] b, input int len);
        fv_pair_t word;
        @(negedge clk);
        // previous burst has to leave first
        while (bank_busy[b]) begin
            @(negedge clk);
        end
        for (int i = 0; i < len; i++) begin
            word = $random(seed);
            exp_q[b].push_back(word);
            pe_valid[b] = 1'b1;
            pe_sos[b]   = (i == 0);
            pe_eos[b]   = (i == len - 1);
            pe_data[b]  = word;
            @(negedge clk);
        end
        pe_valid[b] = 1'b0;
        pe_sos[b]   = 1'b0;
        pe_eos[b]   = 1'b0;
    endtask

    task automatic send_bursts(input logic [bank_idx_w-1:0] b, input int count);
        for (int n = 0; n < count; n++) begin
            send_burst(b, pick_length());
        end
    endtask

    task automatic wait_drained();
        int pending;
        pending = 1;
        while (pending != 0) begin
            @(negedge clk);
            pending = int'(blocked_m);
            for (int b = 0; b < num_pe; b++) begin
                pending += exp_q[b].size();
            end
        end
    endtask

    // all four pes stream at once so bursts overlap with draining
    task automatic fill_banks(input int rounds);
        fork
            send_bursts(2'd0, rounds);
            send_bursts(2'd1, rounds);
            send_bursts(2'd2, rounds);
            send_bursts(2'd3, rounds);
        join
        wait_drained();
    endtask

    // values seen before the edge and the model state updated after
    always @(posedge clk) begin : scoreboard
        logic                  was_blocked;
        logic                  word_ok;
        fv_pair_t              exp_word;
        logic [bank_idx_w-1:0] idx;
        was_blocked = blocked_m;
        if (reset) begin
            blocked_m = 1'b0;
            ready_m   = '0;
            mask_m    = '1;
            rr_last   = bank_idx_w'(num_pe - 1);
            eos_count = 0;
        end else begin
            assert (rs_available || !rs_valid) else
                report_error("rs_valid high while rs_available low");
            if (rs_valid) begin
                word_ok = was_blocked && exp_q[cur_bank].size() != 0;
                assert (word_ok) else report_error("rs word without a granted burst");
                if (word_ok) begin
                    exp_word = exp_q[cur_bank].pop_front();
                    check_value("rs_data", exp_word, rs_data);
                    check_value("rs_sos", 32'(word_idx == 0), 32'(rs_sos));
                    check_value("rs_eos", 32'(exp_q[cur_bank].size() == 0), 32'(rs_eos));
                    if (word_idx == 0) begin
                        sos_cycle = cycle;
                    end
                    word_idx++;
                    // burst over so the block opens again
                    if (exp_q[cur_bank].size() == 0) begin
                        blocked_m = 1'b0;
                        eos_count++;
                    end
                end
                // burst length as framed by rs_sos and rs_eos
                rs_words = rs_sos ? 1 : rs_words + 1;
                if (rs_eos) begin
                    last_len = rs_words;
                end
            end
            // rotation starts after the last granted bank
            if (!was_blocked && rs_available) begin
                for (int k = 1; k <= num_pe; k++) begin
                    idx = rr_last + bank_idx_w'(k);
                    if (!blocked_m && ready_m[idx] && mask_m[idx]) begin
                        blocked_m    = 1'b1;
                        cur_bank     = idx;
                        rr_last      = idx;
                        ready_m[idx] = 1'b0;
                        word_idx     = 0;
                    end
                end
            end
            for (int b = 0; b < num_pe; b++) begin
                if (pe_valid[b] && !bank_busy[b] && pe_eos[b]) begin
                    ready_m[b]   = 1'b1;
                    eos_cycle[b] = cycle;
                end
            end
            // mask write lands on the ack edge
            if (wb_cyc && wb_stb && wb_we && !wb_ack && wb_adr == reg_enable_adr) begin
                mask_m = wb_dat_w[num_pe-1:0];
            end
        end
    end

    always @(posedge clk) begin : watchdog
        cycle <= cycle + 1;
        if (cycle >= timeout_cycles) begin
            report_error("timeout, the run did not finish within the cycle limit");
            $display("checks: %0d, errors: %0d", checks, errors);
            $display("tests failed");
            $finish;
        end
    end

    initial begin : stimulus
        wb_data_t rdata;
        reset        = 1'b1;
        pe_valid     = '0;
        pe_sos       = '0;
        pe_eos       = '0;
        rs_available = 1'b1;
        wb_cyc       = 1'b0;
        wb_stb       = 1'b0;
        wb_we        = 1'b0;
        wb_adr       = '0;
        wb_dat_w     = '0;
        throttle     = 1'b0;
        test_name    = "reset_state";
        for (int b = 0; b < num_pe; b++) begin
            pe_data[b] = '0;
        end
        repeat (10) @(negedge clk);
        reset = 1'b0;

        check_value("rs_valid", 32'h0, 32'(rs_valid));
        check_value("bank_busy", 32'h0, 32'(bank_busy));
        wb_access(1'b0, reg_enable_adr, '0, rdata);
        check_value("enable reg", 32'hf, rdata);
        wb_access(1'b0, reg_count_adr, '0, rdata);
        check_value("count reg", 32'h0, rdata);
        wb_access(1'b0, reg_busy_adr, '0, rdata);
        check_value("busy reg", 32'h0, rdata);

        // idle block gives two cycles from eos to first word
        test_name = "single_burst";
        send_burst(2'd2, 6);
        wait_drained();
        check_value("burst length", 32'd6, 32'(last_len));
        check_value("first word latency", 32'd2, 32'(sos_cycle - eos_cycle[2]));

        test_name = "round_robin";
        fill_banks(3);

        // random stalls on the rs side
        test_name = "back_pressure";
        throttle  = 1'b1;
        fork
            while (throttle) begin
                @(negedge clk);
                rs_available = ($random(seed) & 3) != 0;
            end
            begin
                fill_banks(4);
                throttle = 1'b0;
            end
        join
        rs_available = 1'b1;

        // bank 1 masked off and its burst held
        test_name = "enable_mask";
        wb_access(1'b1, reg_enable_adr, 32'hd, rdata);
        send_burst(2'd1, 5);
        repeat (20) @(negedge clk);
        check_value("bank_busy", 32'h2, 32'(bank_busy));
        wb_access(1'b0, reg_busy_adr, '0, rdata);
        check_value("busy reg", 32'h2, rdata);
        wb_access(1'b1, reg_enable_adr, 32'hf, rdata);
        wait_drained();

        test_name = "burst_count";
        wb_access(1'b0, reg_count_adr, '0, rdata);
        check_value("count reg", 32'(eos_count), rdata);

        $display("checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("all tests passed");
        end else begin
            $display("tests failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* list.f */
verilog/edge_bank_pkg.sv
verilog/bank_stream_if.sv
verilog/edge_buffer_one.sv
verilog/rr_arbiter.sv
verilog/edge_buffer.sv
verilog/bank_config_regs.sv
verilog/edge_bank_top.sv
testbench/edge_bank_properties.sv
testbench/tb_edge_bank.sv

/* Makefile */
# Verilator build and run for the edge bank stage

VERILATOR ?= verilator
TOP       ?= tb_edge_bank
FILELIST  ?= list.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
PASS_MSG  ?= all tests passed
VFLAGS    ?= --timing --assert
JOBS      ?= 0

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) --top-module $(TOP) -f $(FILELIST)

sim:
	$(VERILATOR) --binary $(VFLAGS) -j $(JOBS) --top-module $(TOP) \
		-Mdir $(BUILD_DIR) -f $(FILELIST)
	./$(BUILD_DIR)/V$(TOP) 2>&1 | tee $(LOG)
	@grep -qx "$(PASS_MSG)" $(LOG) && echo "sim: PASS" || \
		(echo "sim: FAIL, see $(LOG)"; exit 1)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
